// ==== src/rv_consts.svh ====
////////////////////
// Sizes and APB address map of the core
// Addresses are byte addresses on a 12-bit APB bus
// Program length field is 7 bits, lengths above 64 wrap the memory
////////////////////
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN           32
`define RV_IMEM_DEPTH     64
`define RV_IMEM_AW        6
`define RV_NREGS          32
`define RV_REG_AW         5
`define RV_LEN_W          7
`define RV_APB_AW         12

// Instruction memory window 0x000 to 0x0FC
`define RV_ADDR_IMEM_BASE 12'h000
// Bits 6:0 length, bit 31 start
`define RV_ADDR_CTRL      12'h100
// Bit 0 done, bit 1 busy
`define RV_ADDR_STATUS    12'h104
// Register readback window 0x200 to 0x27C
`define RV_ADDR_REG_BASE  12'h200

`endif

// ==== src/rv_pkg.sv ====
////////////////////
// Shared types of the RV32I subset core
// Only LUI, OP_IMM and OP opcodes are decoded
////////////////////
package rv_pkg;

  // Major opcodes
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } rv_opcode_e;

  // funct3 of the ALU ops
  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLL = 3'b001,
    F3_XOR = 3'b100,
    F3_SRL = 3'b101,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } rv_funct3_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS  // result is operand b
  } rv_alu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN
  } rv_run_state_e;

endpackage

// ==== src/rv_stage_if.sv ====
////////////////////
// Decode to execute stage link
// wb_* fields double as the forward path into decode
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

interface rv_stage_if import rv_pkg::*; ();

  logic                  valid;
  rv_alu_op_e            alu_op;
  logic [`RV_XLEN-1:0]   operand_a;
  logic [`RV_XLEN-1:0]   operand_b;
  logic [`RV_REG_AW-1:0] rd;

  logic                  wb_en;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;

  modport decode_mp (
    output valid, alu_op, operand_a, operand_b, rd,
    input  wb_en, wb_rd, wb_data
  );

  modport exec_mp (
    input  valid, alu_op, operand_a, operand_b, rd,
    output wb_en, wb_rd, wb_data
  );

endinterface

// ==== src/apb_host_port.sv ====
////////////////////
// APB slave of the core, no wait states
// Low two address bits are ignored in the memory and register windows
// Memory writes while busy are dropped and flagged with PSLVERR
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

module apb_host_port (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   apb_psel_i,
  input  logic                   apb_penable_i,
  input  logic                   apb_pwrite_i,
  input  logic [`RV_APB_AW-1:0]  apb_paddr_i,
  input  logic [`RV_XLEN-1:0]    apb_pwdata_i,
  output logic [`RV_XLEN-1:0]    apb_prdata_o,
  output logic                   apb_pready_o,
  output logic                   apb_pslverr_o,
  output logic                   imem_we_o,
  output logic [`RV_IMEM_AW-1:0] imem_addr_o,
  output logic [`RV_XLEN-1:0]    imem_wdata_o,
  output logic                   start_o,
  output logic [`RV_LEN_W-1:0]   prog_len_o,
  input  logic                   busy_i,
  input  logic                   done_i,
  output logic [`RV_REG_AW-1:0]  reg_raddr_o,
  input  logic [`RV_XLEN-1:0]    reg_rdata_i
);

  localparam logic [`RV_APB_AW-1:0] IMEM_BASE = `RV_ADDR_IMEM_BASE;
  localparam logic [`RV_APB_AW-1:0] REG_BASE  = `RV_ADDR_REG_BASE;

  logic                 access;
  logic                 wr;
  logic                 imem_hit;
  logic                 ctrl_hit;
  logic                 status_hit;
  logic                 reg_hit;
  logic                 mapped;
  logic [`RV_LEN_W-1:0] len_q;  // last written length, for readback

  assign access     = apb_psel_i && apb_penable_i;
  assign wr         = access && apb_pwrite_i;
  assign imem_hit   = apb_paddr_i[`RV_APB_AW-1:8] == IMEM_BASE[`RV_APB_AW-1:8];
  assign reg_hit    = apb_paddr_i[`RV_APB_AW-1:7] == REG_BASE[`RV_APB_AW-1:7];
  assign ctrl_hit   = apb_paddr_i == `RV_ADDR_CTRL;
  assign status_hit = apb_paddr_i == `RV_ADDR_STATUS;
  assign mapped     = imem_hit || ctrl_hit || status_hit || reg_hit;

  assign imem_we_o    = wr && imem_hit && !busy_i;
  assign imem_addr_o  = apb_paddr_i[`RV_IMEM_AW+1:2];
  assign imem_wdata_o = apb_pwdata_i;
  assign start_o      = wr && ctrl_hit && apb_pwdata_i[31];
  assign prog_len_o   = apb_pwdata_i[`RV_LEN_W-1:0];
  assign reg_raddr_o  = apb_paddr_i[`RV_REG_AW+1:2];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      len_q <= '0;
    end else if (wr && ctrl_hit) begin
      len_q <= apb_pwdata_i[`RV_LEN_W-1:0];
    end
  end

  always_comb begin
    apb_prdata_o = '0;
    if (access && !apb_pwrite_i) begin
      if (status_hit) apb_prdata_o = {{(`RV_XLEN-2){1'b0}}, busy_i, done_i};
      else if (ctrl_hit) apb_prdata_o = {{(`RV_XLEN-`RV_LEN_W){1'b0}}, len_q};
      else if (reg_hit) apb_prdata_o = reg_rdata_i;
    end
  end

  assign apb_pready_o  = 1'b1;
  assign apb_pslverr_o = access && (!mapped ||
                         (apb_pwrite_i && (status_hit || reg_hit)) ||
                         (apb_pwrite_i && imem_hit && busy_i));

endmodule

// ==== src/instr_fetch.sv ====
////////////////////
// Instruction memory, PC and run control
// Start is only taken in IDLE, done stays set until the next start
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

module instr_fetch import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   imem_we_i,
  input  logic [`RV_IMEM_AW-1:0] imem_addr_i,
  input  logic [`RV_XLEN-1:0]    imem_wdata_i,
  input  logic                   start_i,
  input  logic [`RV_LEN_W-1:0]   prog_len_i,
  input  logic                   retire_i,
  output logic [`RV_XLEN-1:0]    instr_o,
  output logic                   instr_valid_o,
  input  logic                   decode_ready_i,
  output logic                   busy_o,
  output logic                   done_o
);

  logic [`RV_XLEN-1:0]  imem [`RV_IMEM_DEPTH];
  rv_run_state_e        state_q;
  logic [`RV_LEN_W-1:0] pc_q;
  logic [`RV_LEN_W-1:0] len_q;
  logic [`RV_LEN_W-1:0] retired_q;
  logic [`RV_LEN_W-1:0] retired_next;
  logic                 done_q;
  logic                 fetch_go;
  logic                 load;

  assign fetch_go     = !instr_valid_o || decode_ready_i;  // output reg free
  assign load         = (state_q == ST_RUN) && fetch_go && (pc_q < len_q);
  assign retired_next = retired_q + {{(`RV_LEN_W-1){1'b0}}, retire_i};

  always_ff @(posedge clk) begin
    if (imem_we_i) imem[imem_addr_i] <= imem_wdata_i;
  end

  always_ff @(posedge clk) begin
    if (load) instr_o <= imem[pc_q[`RV_IMEM_AW-1:0]];
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q       <= ST_IDLE;
      pc_q          <= '0;
      len_q         <= '0;
      retired_q     <= '0;
      done_q        <= 1'b0;
      instr_valid_o <= 1'b0;
    end else begin
      retired_q <= retired_next;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            pc_q      <= '0;
            retired_q <= '0;
            len_q     <= prog_len_i;
            done_q    <= (prog_len_i == '0);  // empty program is done at once
            if (prog_len_i != '0) state_q <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (load) begin
            instr_valid_o <= 1'b1;
            pc_q          <= pc_q + {{(`RV_LEN_W-1){1'b0}}, 1'b1};
          end else if (fetch_go) begin
            instr_valid_o <= 1'b0;
            state_q       <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (retired_next == len_q) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign busy_o = state_q != ST_IDLE;
  assign done_o = done_q;

endmodule

// ==== src/instr_decode.sv ====
////////////////////
// Decode stage with forwarding from execute
// Unsupported encodings become PASS with rd = x0
// Always ready, since execute never stalls
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

module instr_decode import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic [`RV_XLEN-1:0]   instr_i,
  input  logic                  instr_valid_i,
  output logic                  decode_ready_o,
  output logic [`RV_REG_AW-1:0] rs1_o,
  output logic [`RV_REG_AW-1:0] rs2_o,
  input  logic [`RV_XLEN-1:0]   rs1_data_i,
  input  logic [`RV_XLEN-1:0]   rs2_data_i,
  rv_stage_if.decode_mp         stage
);

  rv_opcode_e            opcode;
  rv_funct3_e            funct3;
  logic [6:0]            funct7;
  logic [`RV_REG_AW-1:0] rd_f;
  logic [`RV_XLEN-1:0]   u_imm;
  logic [`RV_XLEN-1:0]   i_imm;
  logic [`RV_XLEN-1:0]   imm;
  logic                  use_rs1;
  logic                  use_imm;
  rv_alu_op_e            alu_op_d;
  logic [`RV_REG_AW-1:0] rd_d;
  logic                  fwd_a;
  logic                  fwd_b;
  logic [`RV_XLEN-1:0]   rs1_val;
  logic [`RV_XLEN-1:0]   rs2_val;

  assign opcode = rv_opcode_e'(instr_i[6:0]);
  assign rd_f   = instr_i[11:7];
  assign funct3 = rv_funct3_e'(instr_i[14:12]);
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign u_imm = {instr_i[31:12], 12'b0};
  assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};

  assign decode_ready_o = 1'b1;

  always_comb begin
    alu_op_d = ALU_PASS;
    rd_d     = '0;
    use_rs1  = 1'b0;
    use_imm  = 1'b0;
    imm      = i_imm;
    case (opcode)
      OPC_LUI: begin
        rd_d    = rd_f;
        use_imm = 1'b1;
        imm     = u_imm;
      end
      OPC_OP_IMM: begin
        rd_d    = rd_f;
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          F3_ADD: alu_op_d = ALU_ADD;
          F3_XOR: alu_op_d = ALU_XOR;
          F3_OR:  alu_op_d = ALU_OR;
          F3_AND: alu_op_d = ALU_AND;
          F3_SLL: if (funct7 == 7'b0) alu_op_d = ALU_SLL; else rd_d = '0;
          F3_SRL: if (funct7 == 7'b0) alu_op_d = ALU_SRL; else rd_d = '0;  // no SRAI
          default: rd_d = '0;
        endcase
      end
      OPC_OP: begin
        rd_d    = rd_f;
        use_rs1 = 1'b1;
        case (funct3)
          F3_ADD: alu_op_d = funct7[5] ? ALU_SUB : ALU_ADD;
          F3_XOR: alu_op_d = ALU_XOR;
          F3_OR:  alu_op_d = ALU_OR;
          F3_AND: alu_op_d = ALU_AND;
          default: rd_d = '0;
        endcase
      end
      default: ;
    endcase
  end

  // Result still in execute, not yet in the register file
  assign fwd_a   = stage.wb_en && (stage.wb_rd == rs1_o) && (rs1_o != '0);
  assign fwd_b   = stage.wb_en && (stage.wb_rd == rs2_o) && (rs2_o != '0);
  assign rs1_val = fwd_a ? stage.wb_data : rs1_data_i;
  assign rs2_val = fwd_b ? stage.wb_data : rs2_data_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      stage.valid <= 1'b0;
    end else if (decode_ready_o) begin
      stage.valid <= instr_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid_i && decode_ready_o) begin
      stage.alu_op    <= alu_op_d;
      stage.operand_a <= use_rs1 ? rs1_val : '0;
      stage.operand_b <= use_imm ? imm : rs2_val;
      stage.rd        <= rd_d;
    end
  end

endmodule

// ==== src/reg_file.sv ====
////////////////////
// Architectural registers, x0 reads zero
// Reads are combinational, no write-to-read bypass
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic [`RV_REG_AW-1:0] rs1_i,
  input  logic [`RV_REG_AW-1:0] rs2_i,
  output logic [`RV_XLEN-1:0]   rs1_data_o,
  output logic [`RV_XLEN-1:0]   rs2_data_o,
  input  logic                  wb_en_i,
  input  logic [`RV_REG_AW-1:0] wb_rd_i,
  input  logic [`RV_XLEN-1:0]   wb_data_i,
  input  logic [`RV_REG_AW-1:0] host_raddr_i,
  output logic [`RV_XLEN-1:0]   host_rdata_o
);

  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];  // no storage for x0

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  assign rs1_data_o   = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o   = (rs2_i == '0) ? '0 : regs[rs2_i];
  assign host_rdata_o = (host_raddr_i == '0) ? '0 : regs[host_raddr_i];

endmodule

// ==== src/exec_unit.sv ====
////////////////////
// Execute and writeback stage
// Shifts use the low 5 bits of operand b
// retire_o follows the register write by one cycle
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

module exec_unit import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,
  rv_stage_if.exec_mp stage,
  output logic        retire_o
);

  logic [`RV_XLEN-1:0] result;
  logic [4:0]          shamt;
  logic                retire_q;

  assign shamt = stage.operand_b[4:0];

  always_comb begin
    case (stage.alu_op)
      ALU_ADD: result = stage.operand_a + stage.operand_b;
      ALU_SUB: result = stage.operand_a - stage.operand_b;  // wraps on borrow
      ALU_XOR: result = stage.operand_a ^ stage.operand_b;
      ALU_OR:  result = stage.operand_a | stage.operand_b;
      ALU_AND: result = stage.operand_a & stage.operand_b;
      ALU_SLL: result = stage.operand_a << shamt;
      ALU_SRL: result = stage.operand_a >> shamt;
      default: result = stage.operand_b;  // PASS for LUI
    endcase
  end

  // Also the forward source seen by decode
  assign stage.wb_en   = stage.valid && (stage.rd != '0);
  assign stage.wb_rd   = stage.rd;
  assign stage.wb_data = result;

  // No-ops retire too, so fetch can match the count to the length
  always_ff @(posedge clk) begin
    if (rst_i) begin
      retire_q <= 1'b0;
    end else begin
      retire_q <= stage.valid;
    end
  end

  assign retire_o = retire_q;

endmodule

// ==== src/rv_core_top.sv ====
////////////////////
// RV32I subset core with APB host access
// Load memory, write length with start, poll done, read registers
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  apb_psel_i,
  input  logic                  apb_penable_i,
  input  logic                  apb_pwrite_i,
  input  logic [`RV_APB_AW-1:0] apb_paddr_i,
  input  logic [`RV_XLEN-1:0]   apb_pwdata_i,
  output logic [`RV_XLEN-1:0]   apb_prdata_o,
  output logic                  apb_pready_o,
  output logic                  apb_pslverr_o
);

  logic                   imem_we;
  logic [`RV_IMEM_AW-1:0] imem_addr;
  logic [`RV_XLEN-1:0]    imem_wdata;
  logic                   start;
  logic [`RV_LEN_W-1:0]   prog_len;
  logic                   busy;
  logic                   done;
  logic                   retire;
  logic [`RV_XLEN-1:0]    instr;
  logic                   instr_valid;
  logic                   decode_ready;
  logic [`RV_REG_AW-1:0]  rs1;
  logic [`RV_REG_AW-1:0]  rs2;
  logic [`RV_XLEN-1:0]    rs1_data;
  logic [`RV_XLEN-1:0]    rs2_data;
  logic [`RV_REG_AW-1:0]  host_raddr;
  logic [`RV_XLEN-1:0]    host_rdata;

  rv_stage_if stage_if ();

  apb_host_port apb_host_port_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .apb_psel_i    (apb_psel_i),
    .apb_penable_i (apb_penable_i),
    .apb_pwrite_i  (apb_pwrite_i),
    .apb_paddr_i   (apb_paddr_i),
    .apb_pwdata_i  (apb_pwdata_i),
    .apb_prdata_o  (apb_prdata_o),
    .apb_pready_o  (apb_pready_o),
    .apb_pslverr_o (apb_pslverr_o),
    .imem_we_o     (imem_we),
    .imem_addr_o   (imem_addr),
    .imem_wdata_o  (imem_wdata),
    .start_o       (start),
    .prog_len_o    (prog_len),
    .busy_i        (busy),
    .done_i        (done),
    .reg_raddr_o   (host_raddr),
    .reg_rdata_i   (host_rdata)
  );

  instr_fetch instr_fetch_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .imem_we_i      (imem_we),
    .imem_addr_i    (imem_addr),
    .imem_wdata_i   (imem_wdata),
    .start_i        (start),
    .prog_len_i     (prog_len),
    .retire_i       (retire),
    .instr_o        (instr),
    .instr_valid_o  (instr_valid),
    .decode_ready_i (decode_ready),
    .busy_o         (busy),
    .done_o         (done)
  );

  instr_decode instr_decode_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .instr_i        (instr),
    .instr_valid_i  (instr_valid),
    .decode_ready_o (decode_ready),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .stage          (stage_if)
  );

  reg_file reg_file_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rs1_data_o   (rs1_data),
    .rs2_data_o   (rs2_data),
    .wb_en_i      (stage_if.wb_en),
    .wb_rd_i      (stage_if.wb_rd),
    .wb_data_i    (stage_if.wb_data),
    .host_raddr_i (host_raddr),
    .host_rdata_o (host_rdata)
  );

  exec_unit exec_unit_inst (
    .clk      (clk),
    .rst_i    (rst_i),
    .stage    (stage_if),
    .retire_o (retire)
  );

endmodule

// ==== testbench/tb_rv_core.sv ====
////////////////////
// Testbench of the RV32I subset core over APB
// Register state carries over from one test to the next
// Expected values come from a model of the ISA subset
////////////////////
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam int NUM_TESTS   = 6;
  localparam int MAX_PROG    = `RV_IMEM_DEPTH;
  localparam int XFER_CYCLES = 3;
  localparam int TEST_XFERS  = 2 * MAX_PROG + 48;  // Load, polls, readback, extras
  localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_XFERS * XFER_CYCLES * 6;
  localparam logic [11:0] ADDR_CTRL   = `RV_ADDR_CTRL;
  localparam logic [11:0] ADDR_STATUS = `RV_ADDR_STATUS;
  localparam logic [11:0] ADDR_REGS   = `RV_ADDR_REG_BASE;

  logic        clk;
  logic        rst_i;
  logic        apb_psel;
  logic        apb_penable;
  logic        apb_pwrite;
  logic [11:0] apb_paddr;
  logic [31:0] apb_pwdata;
  logic [31:0] apb_prdata;
  logic        apb_pready;
  logic        apb_pslverr;

  integer      seed;
  int          errors;
  int          tests_failed;
  int          cycle_count;
  int          n_instr;
  logic [31:0] prog [MAX_PROG];
  logic [31:0] exp_regs [32];

  rv_core_top rv_core_top_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .apb_psel_i    (apb_psel),
    .apb_penable_i (apb_penable),
    .apb_pwrite_i  (apb_pwrite),
    .apb_paddr_i   (apb_paddr),
    .apb_pwdata_i  (apb_pwdata),
    .apb_prdata_o  (apb_prdata),
    .apb_pready_o  (apb_pready),
    .apb_pslverr_o (apb_pslverr)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  // ISA model of the subset, runs prog[] on exp_regs
  function automatic void ref_run(input int len);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        wr;
    for (int i = 0; i < len; i++) begin
      ins = prog[i];
      f3  = ins[14:12];
      f7  = ins[31:25];
      a   = exp_regs[ins[19:15]];
      b   = exp_regs[ins[24:20]];
      imm = {{20{ins[31]}}, ins[31:20]};
      wr  = 1'b1;
      res = '0;
      case (ins[6:0])
        7'b0110111: res = {ins[31:12], 12'h000};
        7'b0010011: begin
          case (f3)
            3'b000: res = a + imm;
            3'b100: res = a ^ imm;
            3'b110: res = a | imm;
            3'b111: res = a & imm;
            3'b001: if (f7 == 7'b0) res = a << ins[24:20]; else wr = 1'b0;
            3'b101: if (f7 == 7'b0) res = a >> ins[24:20]; else wr = 1'b0;
            default: wr = 1'b0;
          endcase
        end
        7'b0110011: begin
          case (f3)
            3'b000: res = f7[5] ? a - b : a + b;
            3'b100: res = a ^ b;
            3'b110: res = a | b;
            3'b111: res = a & b;
            default: wr = 1'b0;
          endcase
        end
        default: wr = 1'b0;  // Unknown opcode
      endcase
      if (wr && ins[11:7] != 5'd0) exp_regs[ins[11:7]] = res;
    end
  endfunction

  // Setup, access, then idle; samples in the low half of the access phase
  task automatic apb_xfer(input logic write, input logic [11:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(posedge clk);
    #1;
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = write;
    apb_paddr   = addr;
    apb_pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_penable = 1'b1;
    @(negedge clk);
    rdata = apb_prdata;
    err   = apb_pslverr;
    if (apb_pready !== 1'b1) begin
      $display("PREADY low in access phase at address %h", addr);
      errors++;
    end
    @(posedge clk);
    #1;
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
  endtask

  task automatic push_instr(input logic [31:0] word);
    prog[n_instr] = word;
    n_instr++;
  endtask

  task automatic load_prog(input int len);
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < len; i++) begin
      apb_xfer(1'b1, 12'(i * 4), prog[i], rdata, err);
      if (err) begin
        $display("Unexpected PSLVERR while loading word %0d", i);
        errors++;
      end
    end
  endtask

  task automatic start_run(input int len);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, ADDR_CTRL, 32'h8000_0000 | 32'(len), rdata, err);
    if (err) begin
      $display("Unexpected PSLVERR on start of a %0d word run", len);
      errors++;
    end
  endtask

  task automatic wait_done();
    logic [31:0] rdata;
    logic        err;
    do begin
      apb_xfer(1'b0, ADDR_STATUS, 32'h0, rdata, err);
    end while (rdata[0] !== 1'b1);
  endtask

  task automatic compare_regs(input string name);
    logic [31:0] rdata;
    logic        err;
    for (int r = 1; r < `RV_NREGS; r++) begin
      apb_xfer(1'b0, ADDR_REGS + 12'(r * 4), 32'h0, rdata, err);
      if (rdata !== exp_regs[r]) begin
        $display("[FAIL] %s x%0d: expected %h actual %h", name, r, exp_regs[r], rdata);
        errors++;
      end
      if (err) begin
        $display("Unexpected PSLVERR on readback of x%0d in %s", r, name);
        errors++;
      end
    end
  endtask

  task automatic run_and_compare(input string name);
    load_prog(n_instr);
    ref_run(n_instr);
    start_run(n_instr);
    wait_done();
    compare_regs(name);
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  task automatic gen_random(input int len);
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  last_rd;
    logic [11:0] imm;
    last_rd = 5'd1;
    for (int i = 0; i < len; i++) begin
      kind = $unsigned($random(seed)) % 12;
      rd   = 5'($random(seed));
      rs1  = ($random(seed) & 1) ? last_rd : 5'($random(seed));  // Favor dependencies
      rs2  = 5'($random(seed));
      imm  = 12'($random(seed));
      case (kind)
        0: push_instr(enc_lui(rd, 20'($random(seed))));
        1: push_instr(enc_i(F3_ADD, rd, rs1, imm));
        2: push_instr(enc_i(F3_XOR, rd, rs1, imm));
        3: push_instr(enc_i(F3_OR, rd, rs1, imm));
        4: push_instr(enc_i(F3_AND, rd, rs1, imm));
        5: push_instr(enc_i(F3_SLL, rd, rs1, {7'b0, imm[4:0]}));
        6: push_instr(enc_i(F3_SRL, rd, rs1, {7'b0, imm[4:0]}));
        7: push_instr(enc_r(7'b0000000, F3_ADD, rd, rs1, rs2));
        8: push_instr(enc_r(7'b0100000, F3_ADD, rd, rs1, rs2));
        9: push_instr(enc_r(7'b0000000, F3_XOR, rd, rs1, rs2));
        10: push_instr(enc_r(7'b0000000, F3_OR, rd, rs1, rs2));
        default: push_instr(enc_r(7'b0000000, F3_AND, rd, rs1, rs2));
      endcase
      last_rd = rd;
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          errs_before;
    clk          = 1'b0;
    rst_i        = 1'b1;
    apb_psel     = 1'b0;
    apb_penable  = 1'b0;
    apb_pwrite   = 1'b0;
    apb_paddr    = '0;
    apb_pwdata   = '0;
    seed         = 65;
    errors       = 0;
    tests_failed = 0;
    cycle_count  = 0;
    for (int r = 0; r < 32; r++) exp_regs[r] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_i = 1'b0;

    errs_before = errors;
    n_instr = 0;
    push_instr(enc_lui(5'd1, 20'h12345));
    push_instr(enc_i(F3_ADD, 5'd2, 5'd1, 12'h678));
    push_instr(enc_i(F3_ADD, 5'd3, 5'd0, 12'hFFB));  // -5
    push_instr(enc_i(F3_XOR, 5'd4, 5'd3, 12'h0F0));
    push_instr(enc_i(F3_OR, 5'd5, 5'd1, 12'h00F));
    push_instr(enc_i(F3_AND, 5'd6, 5'd3, 12'h7F0));
    push_instr(enc_i(F3_SLL, 5'd7, 5'd3, 12'd4));
    push_instr(enc_i(F3_SRL, 5'd8, 5'd3, 12'd28));
    push_instr(enc_lui(5'd9, 20'hFFFFF));
    push_instr(enc_i(F3_ADD, 5'd10, 5'd9, 12'h7FF));
    run_and_compare("imm_ops");
    end_test("imm_ops", errs_before);

    errs_before = errors;
    n_instr = 0;
    push_instr(enc_r(7'b0000000, F3_ADD, 5'd11, 5'd1, 5'd3));
    push_instr(enc_r(7'b0100000, F3_ADD, 5'd12, 5'd0, 5'd1));  // Borrows around
    push_instr(enc_r(7'b0100000, F3_ADD, 5'd13, 5'd3, 5'd1));
    push_instr(enc_r(7'b0000000, F3_XOR, 5'd14, 5'd1, 5'd9));
    push_instr(enc_r(7'b0000000, F3_OR, 5'd15, 5'd5, 5'd6));
    push_instr(enc_r(7'b0000000, F3_AND, 5'd16, 5'd9, 5'd1));
    push_instr(enc_r(7'b0000000, F3_ADD, 5'd17, 5'd11, 5'd12));
    run_and_compare("reg_ops");
    end_test("reg_ops", errs_before);

    errs_before = errors;
    n_instr = 0;
    push_instr(enc_i(F3_ADD, 5'd20, 5'd0, 12'd7));
    push_instr(enc_i(F3_SLL, 5'd21, 5'd20, 12'd3));
    push_instr(enc_r(7'b0100000, F3_ADD, 5'd22, 5'd21, 5'd20));
    push_instr(enc_r(7'b0000000, F3_XOR, 5'd23, 5'd22, 5'd21));
    push_instr(enc_r(7'b0000000, F3_ADD, 5'd24, 5'd23, 5'd23));
    push_instr(enc_i(F3_SRL, 5'd25, 5'd24, 12'd1));
    push_instr(enc_r(7'b0000000, F3_OR, 5'd26, 5'd25, 5'd20));
    push_instr(enc_i(F3_AND, 5'd27, 5'd26, 12'h0FF));
    push_instr(enc_i(F3_ADD, 5'd28, 5'd27, 12'hFFF));
    run_and_compare("forward_chain");
    end_test("forward_chain", errs_before);

    errs_before = errors;
    n_instr = 0;
    push_instr(enc_i(F3_ADD, 5'd0, 5'd0, 12'd5));
    push_instr(enc_i(F3_ADD, 5'd29, 5'd0, 12'h055));
    push_instr(enc_lui(5'd0, 20'hABCDE));
    push_instr(enc_r(7'b0000000, F3_ADD, 5'd0, 5'd1, 5'd1));
    push_instr({20'hABCDE, 5'd30, 7'b0001011});  // Custom opcode
    push_instr(enc_r(7'b0000000, 3'b010, 5'd31, 5'd1, 5'd3));  // SLT, unsupported
    run_and_compare("x0_unknown");
    apb_xfer(1'b0, ADDR_REGS, 32'h0, rdata, err);
    if (rdata !== 32'h0) begin
      $display("[FAIL] x0_unknown x0: expected %h actual %h", 32'h0, rdata);
      errors++;
    end
    end_test("x0_unknown", errs_before);

    errs_before = errors;
    apb_xfer(1'b0, 12'h300, 32'h0, rdata, err);
    if (err !== 1'b1) begin
      $display("[FAIL] apb_errors unmapped read: expected 1 actual %b", err);
      errors++;
    end
    apb_xfer(1'b1, ADDR_STATUS, 32'h3, rdata, err);
    if (err !== 1'b1) begin
      $display("[FAIL] apb_errors status write: expected 1 actual %b", err);
      errors++;
    end
    n_instr = 0;
    for (int i = 0; i < 40; i++) push_instr(enc_i(F3_ADD, 5'd30, 5'd30, 12'd3));
    load_prog(n_instr);
    ref_run(n_instr);
    start_run(n_instr);
    apb_xfer(1'b0, ADDR_STATUS, 32'h0, rdata, err);
    if (rdata[1] !== 1'b1) begin
      $display("[FAIL] apb_errors busy: expected 1 actual %b", rdata[1]);
      errors++;
    end
    apb_xfer(1'b1, 12'h000, 32'h0, rdata, err);  // Dropped by the DUT
    if (err !== 1'b1) begin
      $display("[FAIL] apb_errors imem write busy: expected 1 actual %b", err);
      errors++;
    end
    wait_done();
    apb_xfer(1'b0, ADDR_STATUS, 32'h0, rdata, err);
    if (rdata[1:0] !== 2'b01) begin
      $display("[FAIL] apb_errors status after run: expected %b actual %b", 2'b01, rdata[1:0]);
      errors++;
    end
    apb_xfer(1'b0, ADDR_CTRL, 32'h0, rdata, err);
    if (rdata[6:0] !== 7'(n_instr)) begin
      $display("[FAIL] apb_errors length readback: expected %h actual %h",
               7'(n_instr), rdata[6:0]);
      errors++;
    end
    compare_regs("apb_errors");
    end_test("apb_errors", errs_before);

    errs_before = errors;
    n_instr = 0;
    gen_random(MAX_PROG);
    run_and_compare("random_prog");
    end_test("random_prog", errs_before);

    $display("tests: %0d run, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
+incdir+src
src/rv_pkg.sv
src/rv_stage_if.sv
src/apb_host_port.sv
src/instr_fetch.sv
src/instr_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/rv_core_top.sv
testbench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_rv_core \
  -f rv_core.f \
  -o tb_rv_core

./obj_dir/tb_rv_core | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation finished cleanly"
